// File: nf_pkg.sv
/*
 * shared definitions for the memory and peripheral side
 * bus address and data types, address map, GPIO register offsets
 * and the arbiter state encoding
 */

package nf_pkg;

    // bus word types
    typedef logic [31 : 0]  addr_t;     // byte address, core ports and internal bus
    typedef logic [31 : 0]  data_t;     // read or write data word

    // address map
    localparam addr_t RAM_BASE  = 32'h0000_0000;  // word RAM region start
    localparam addr_t GPIO_BASE = 32'h0001_0000;  // GPIO region start

    // GPIO register offsets inside the region
    localparam addr_t GPIO_GPO_OFS = 32'h0000_0000;   // output value
    localparam addr_t GPIO_GPD_OFS = 32'h0000_0004;   // direction
    localparam addr_t GPIO_GPI_OFS = 32'h0000_0008;   // sampled input, read only

    // cross-connect arbiter states
    typedef enum logic [1 : 0] {
        ARB_IDLE    = 2'b00,    // waiting for a request
        ARB_WAIT_IF = 2'b01,    // instruction port owns the bus
        ARB_WAIT_DM = 2'b10     // data port owns the bus
    } arb_state_t;

endpackage : nf_pkg

// File: nf_cpu_cc.sv
/*
 * cross-connect arbiter
 * merges the instruction and data request ports onto the internal
 * strobe bus, data port has priority
 */

`timescale 1ns/1ps

module nf_cpu_cc
(
    input   logic               clk,            // clock
    input   logic               rst_n_i,        // async reset, active low
    // instruction port
    input   nf_pkg::addr_t      if_addr_i,      // fetch address
    input   logic               if_req_i,       // fetch request, held until ack
    output  nf_pkg::data_t      if_rd_o,        // fetched word
    output  logic               if_req_ack_o,   // one cycle ack pulse
    // data port
    input   nf_pkg::addr_t      dm_addr_i,      // data address
    input   nf_pkg::data_t      dm_wd_i,        // write data
    input   logic               dm_we_i,        // write enable
    input   logic               dm_req_i,       // data request, held until ack
    output  nf_pkg::data_t      dm_rd_o,        // read data
    output  logic               dm_req_ack_o,   // one cycle ack pulse
    // internal bus
    output  nf_pkg::addr_t      bus_addr_o,     // latched address
    output  nf_pkg::data_t      bus_wd_o,       // latched write data
    output  logic               bus_we_o,       // latched write enable
    output  logic               bus_req_o,      // single cycle strobe
    input   nf_pkg::data_t      bus_rd_i,       // read data from decoder
    input   logic               bus_ack_i       // completion pulse from decoder
);

    import nf_pkg::*;

    localparam logic if_we = 1'b0;      // fetch never writes

    arb_state_t state;                  // current owner of the bus
    logic       dm_grant;               // data port wins this cycle
    logic       if_grant;               // instruction port wins this cycle

    assign dm_grant = (state == ARB_IDLE) && dm_req_i;
    assign if_grant = (state == ARB_IDLE) && if_req_i && !dm_req_i;

    // ownership and strobe
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state     <= ARB_IDLE;
            bus_req_o <= 1'b0;
        end else begin
            bus_req_o <= dm_grant || if_grant;      // strobe lasts one cycle
            case (state)
                ARB_IDLE: begin
                    if (dm_grant)
                        state <= ARB_WAIT_DM;
                    else if (if_grant)
                        state <= ARB_WAIT_IF;
                end
                ARB_WAIT_IF,
                ARB_WAIT_DM: begin
                    if (bus_ack_i)
                        state <= ARB_IDLE;          // free again next edge
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // bus payload, captured with the grant
    always_ff @(posedge clk) begin
        if (dm_grant) begin
            bus_addr_o <= dm_addr_i;
            bus_wd_o   <= dm_wd_i;
            bus_we_o   <= dm_we_i;
        end else if (if_grant) begin
            bus_addr_o <= if_addr_i;
            bus_wd_o   <= '0;
            bus_we_o   <= if_we;
        end
    end

    // steer the response to the owner only
    assign dm_req_ack_o = bus_ack_i && (state == ARB_WAIT_DM);
    assign if_req_ack_o = bus_ack_i && (state == ARB_WAIT_IF);
    assign dm_rd_o      = (state == ARB_WAIT_DM) ? bus_rd_i : '0;
    assign if_rd_o      = (state == ARB_WAIT_IF) ? bus_rd_i : '0;

endmodule : nf_cpu_cc

// File: nf_bus_dec.sv
/*
 * internal bus address decoder
 * slave selects, registered region for the return path,
 * read data mux and the bus acknowledge
 */

`timescale 1ns/1ps

module nf_bus_dec
#(
    parameter int depth = 1024                  // RAM words
)
(
    input   logic               clk,            // clock
    input   logic               rst_n_i,        // async reset, active low
    input   nf_pkg::addr_t      bus_addr_i,     // byte address from arbiter
    input   logic               bus_req_i,      // single cycle strobe
    input   nf_pkg::data_t      ram_rd_i,       // RAM read data
    input   nf_pkg::data_t      gpio_rd_i,      // GPIO read data
    output  logic               ram_sel_o,      // RAM select, same cycle as strobe
    output  logic               gpio_sel_o,     // GPIO select, same cycle as strobe
    output  nf_pkg::data_t      bus_rd_o,       // read data back to arbiter
    output  logic               bus_ack_o       // completion pulse
);

    import nf_pkg::*;

    localparam addr_t ram_span  = addr_t'(depth * 4);     // RAM region size in bytes
    localparam addr_t gpio_span = GPIO_GPI_OFS + 32'd4;   // last register included

    addr_t  ram_ofs;        // offset into RAM region
    addr_t  gpio_ofs;       // offset into GPIO region
    logic   ram_hit;
    logic   gpio_hit;
    logic   ram_sel_r;      // RAM was selected last cycle
    logic   gpio_sel_r;     // GPIO was selected last cycle

    // wrap-around subtraction keeps one compare per region
    assign ram_ofs  = bus_addr_i - RAM_BASE;
    assign gpio_ofs = bus_addr_i - GPIO_BASE;
    assign ram_hit  = ram_ofs < ram_span;
    assign gpio_hit = gpio_ofs < gpio_span;

    assign ram_sel_o  = bus_req_i && ram_hit;
    assign gpio_sel_o = bus_req_i && gpio_hit;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ram_sel_r  <= 1'b0;
            gpio_sel_r <= 1'b0;
            bus_ack_o  <= 1'b0;
        end else begin
            ram_sel_r  <= ram_sel_o;
            gpio_sel_r <= gpio_sel_o;
            bus_ack_o  <= bus_req_i;    // unmapped access still completes
        end
    end

    // unmapped read returns zero
    assign bus_rd_o = ram_sel_r  ? ram_rd_i  :
                      gpio_sel_r ? gpio_rd_i : '0;

endmodule : nf_bus_dec

// File: nf_ram.sv
/*
 * word addressed single port RAM slave
 * synchronous write and registered read
 */

`timescale 1ns/1ps

module nf_ram
#(
    parameter int depth = 1024                  // number of words
)
(
    input   logic               clk,            // clock
    input   logic               ram_sel_i,      // select from decoder
    input   logic               ram_we_i,       // write enable
    input   nf_pkg::addr_t      ram_addr_i,     // byte address
    input   nf_pkg::data_t      ram_wd_i,       // write data
    output  nf_pkg::data_t      ram_rd_o        // read data, one cycle after select
);

    import nf_pkg::*;

    localparam int aw = $clog2(depth);  // word index width

    data_t          mem [depth];        // storage
    addr_t          ram_ofs;            // byte offset inside region
    logic [aw-1:0]  word_idx;           // word index

    assign ram_ofs  = ram_addr_i - RAM_BASE;
    assign word_idx = ram_ofs[aw+1 : 2];    // drop byte lanes

    always_ff @(posedge clk) begin
        if (ram_sel_i) begin
            if (ram_we_i)
                mem[word_idx] <= ram_wd_i;
            ram_rd_o <= mem[word_idx];  // holds when not selected
        end
    end

endmodule : nf_ram

// File: nf_gpio.sv
/*
 * GPIO slave
 * output and direction registers, sampled input register
 */

`timescale 1ns/1ps

module nf_gpio
#(
    parameter int gpio_w = 8                    // pin count
)
(
    input   logic                   clk,        // clock
    input   logic                   rst_n_i,    // async reset, active low
    input   logic                   gpio_sel_i, // select from decoder
    input   logic                   gpio_we_i,  // write enable
    input   nf_pkg::addr_t          gpio_addr_i,// byte address
    input   nf_pkg::data_t          gpio_wd_i,  // write data
    input   logic [gpio_w-1 : 0]    gpi_i,      // pin inputs
    output  nf_pkg::data_t          gpio_rd_o,  // read data, one cycle after select
    output  logic [gpio_w-1 : 0]    gpo_o,      // output register
    output  logic [gpio_w-1 : 0]    gpd_o       // direction register
);

    import nf_pkg::*;

    addr_t                  gpio_ofs;   // register offset
    logic [gpio_w-1 : 0]    gpi_r;      // pins sampled every cycle

    assign gpio_ofs = gpio_addr_i - GPIO_BASE;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gpo_o <= '0;
            gpd_o <= '0;
            gpi_r <= '0;
        end else begin
            gpi_r <= gpi_i;
            if (gpio_sel_i && gpio_we_i) begin
                case (gpio_ofs)
                    GPIO_GPO_OFS: gpo_o <= gpio_wd_i[gpio_w-1 : 0];
                    GPIO_GPD_OFS: gpd_o <= gpio_wd_i[gpio_w-1 : 0];
                    default: ;              // input register is read only
                endcase
            end
        end
    end

    // zero-extended register read
    always_ff @(posedge clk) begin
        if (gpio_sel_i) begin
            case (gpio_ofs)
                GPIO_GPO_OFS: gpio_rd_o <= data_t'(gpo_o);
                GPIO_GPD_OFS: gpio_rd_o <= data_t'(gpd_o);
                GPIO_GPI_OFS: gpio_rd_o <= data_t'(gpi_r);
                default:      gpio_rd_o <= '0;
            endcase
        end
    end

endmodule : nf_gpio

// File: nf_top.sv
/*
 * memory and peripheral top level
 * arbiter, address decoder, word RAM and GPIO on one strobe bus
 */

`timescale 1ns/1ps

module nf_top
#(
    parameter int depth  = 1024,                    // RAM words
    parameter int gpio_w = 8                        // GPIO width
)
(
    input   logic                   clk,            // clock
    input   logic                   rst_n_i,        // async reset, active low
    // instruction port
    input   nf_pkg::addr_t          if_addr_i,      // fetch address
    input   logic                   if_req_i,       // fetch request
    output  nf_pkg::data_t          if_rd_o,        // fetched word
    output  logic                   if_req_ack_o,   // fetch ack
    // data port
    input   nf_pkg::addr_t          dm_addr_i,      // data address
    input   nf_pkg::data_t          dm_wd_i,        // write data
    input   logic                   dm_we_i,        // write enable
    input   logic                   dm_req_i,       // data request
    output  nf_pkg::data_t          dm_rd_o,        // read data
    output  logic                   dm_req_ack_o,   // data ack
    // GPIO pins
    input   logic [gpio_w-1 : 0]    gpi_i,          // pin inputs
    output  logic [gpio_w-1 : 0]    gpo_o,          // pin outputs
    output  logic [gpio_w-1 : 0]    gpd_o           // pin directions
);

    import nf_pkg::*;

    // internal bus
    addr_t  bus_addr;       // shared address to slaves
    data_t  bus_wd;         // shared write data
    logic   bus_we;         // shared write enable
    logic   bus_req;        // strobe from arbiter
    data_t  bus_rd;         // muxed read data
    logic   bus_ack;        // completion pulse
    // slave side
    logic   ram_sel;
    logic   gpio_sel;
    data_t  ram_rd;
    data_t  gpio_rd;

    nf_cpu_cc nf_cpu_cc_0
    (
        .clk            ( clk           ),
        .rst_n_i        ( rst_n_i       ),
        .if_addr_i      ( if_addr_i     ),
        .if_req_i       ( if_req_i      ),
        .if_rd_o        ( if_rd_o       ),
        .if_req_ack_o   ( if_req_ack_o  ),
        .dm_addr_i      ( dm_addr_i     ),
        .dm_wd_i        ( dm_wd_i       ),
        .dm_we_i        ( dm_we_i       ),
        .dm_req_i       ( dm_req_i      ),
        .dm_rd_o        ( dm_rd_o       ),
        .dm_req_ack_o   ( dm_req_ack_o  ),
        .bus_addr_o     ( bus_addr      ),
        .bus_wd_o       ( bus_wd        ),
        .bus_we_o       ( bus_we        ),
        .bus_req_o      ( bus_req       ),
        .bus_rd_i       ( bus_rd        ),
        .bus_ack_i      ( bus_ack       )
    );

    nf_bus_dec #( .depth ( depth ) ) nf_bus_dec_0
    (
        .clk            ( clk           ),
        .rst_n_i        ( rst_n_i       ),
        .bus_addr_i     ( bus_addr      ),
        .bus_req_i      ( bus_req       ),
        .ram_rd_i       ( ram_rd        ),
        .gpio_rd_i      ( gpio_rd       ),
        .ram_sel_o      ( ram_sel       ),
        .gpio_sel_o     ( gpio_sel      ),
        .bus_rd_o       ( bus_rd        ),
        .bus_ack_o      ( bus_ack       )
    );

    // instruction and data share this RAM
    nf_ram #( .depth ( depth ) ) nf_ram_0
    (
        .clk            ( clk           ),
        .ram_sel_i      ( ram_sel       ),
        .ram_we_i       ( bus_we        ),
        .ram_addr_i     ( bus_addr      ),
        .ram_wd_i       ( bus_wd        ),
        .ram_rd_o       ( ram_rd        )
    );

    nf_gpio #( .gpio_w ( gpio_w ) ) nf_gpio_0
    (
        .clk            ( clk           ),
        .rst_n_i        ( rst_n_i       ),
        .gpio_sel_i     ( gpio_sel      ),
        .gpio_we_i      ( bus_we        ),
        .gpio_addr_i    ( bus_addr      ),
        .gpio_wd_i      ( bus_wd        ),
        .gpi_i          ( gpi_i         ),
        .gpio_rd_o      ( gpio_rd       ),
        .gpo_o          ( gpo_o         ),
        .gpd_o          ( gpd_o         )
    );

endmodule : nf_top

// File: nf_top_chk.sv
/*
 * handshake assertions on the core ports of nf_top
 * attached to every nf_top instance by bind
 */

`timescale 1ns/1ps

module nf_top_chk
(
    input   logic   clk,        // clock
    input   logic   rst_n_i,    // async reset, active low
    input   logic   if_req_i,   // fetch request
    input   logic   if_ack_i,   // fetch ack
    input   logic   dm_req_i,   // data request
    input   logic   dm_ack_i    // data ack
);

    int fails = 0;  // count of failed assertions

    a_if_pulse: assert property (@(posedge clk) disable iff (!rst_n_i) if_ack_i |=> !if_ack_i)
        else begin
            $error("fetch ack longer than one cycle");
            fails = fails + 1;
        end

    a_dm_pulse: assert property (@(posedge clk) disable iff (!rst_n_i) dm_ack_i |=> !dm_ack_i)
        else begin
            $error("data ack longer than one cycle");
            fails = fails + 1;
        end

    a_one_owner: assert property (@(posedge clk) disable iff (!rst_n_i) !(if_ack_i && dm_ack_i))
        else begin
            $error("both acks at once");
            fails = fails + 1;
        end

    a_if_req: assert property (@(posedge clk) disable iff (!rst_n_i) if_ack_i |-> if_req_i)
        else begin
            $error("fetch ack without request");
            fails = fails + 1;
        end

    a_dm_req: assert property (@(posedge clk) disable iff (!rst_n_i) dm_ack_i |-> dm_req_i)
        else begin
            $error("data ack without request");
            fails = fails + 1;
        end

    // no disable here, reset itself is checked
    a_reset_quiet: assert property (@(posedge clk) !rst_n_i |-> !(if_ack_i || dm_ack_i))
        else begin
            $error("ack while in reset");
            fails = fails + 1;
        end

endmodule : nf_top_chk

bind nf_top nf_top_chk nf_top_chk_0
(
    .clk        ( clk           ),
    .rst_n_i    ( rst_n_i       ),
    .if_req_i   ( if_req_i      ),
    .if_ack_i   ( if_req_ack_o  ),
    .dm_req_i   ( dm_req_i      ),
    .dm_ack_i   ( dm_req_ack_o  )
);

// File: nf_top_tb.sv
/*
 * testbench for nf_top
 * clock and reset, operation table, random RAM phase,
 * port contention and a cycle timeout
 */

`timescale 1ns/1ps

module nf_top_tb;

    import nf_pkg::*;

    localparam int   depth   = 1024;        // RAM words
    localparam int   gpio_w  = 8;           // GPIO width
    localparam int   n_rand  = 32;          // random RAM words
    localparam logic port_dm = 1'b0;
    localparam logic port_if = 1'b1;

    typedef logic [gpio_w-1 : 0] pins_t;

    typedef struct packed {
        logic   port;       // requesting port
        logic   we;         // write flag
        addr_t  addr;
        data_t  wd;
        pins_t  gpi;        // pins held during the access
        data_t  exp_rd;     // expected read data on reads
        pins_t  exp_gpo;    // gpo_o after the access
        pins_t  exp_gpd;    // gpd_o after the access
    } op_t;

    logic   clk;
    logic   rst_n_i;
    addr_t  if_addr_i;
    logic   if_req_i;
    data_t  if_rd_o;
    logic   if_req_ack_o;
    addr_t  dm_addr_i;
    data_t  dm_wd_i;
    logic   dm_we_i;
    logic   dm_req_i;
    data_t  dm_rd_o;
    logic   dm_req_ack_o;
    pins_t  gpi_i;
    pins_t  gpo_o;
    pins_t  gpd_o;

    op_t    ops [$];            // operation table
    data_t  ref_mem [depth];    // expected RAM contents
    addr_t  raddr [n_rand];     // random phase addresses
    int     cycles = 0;
    int     limit  = 0;         // set once the table is built

    nf_top #( .depth ( depth ), .gpio_w ( gpio_w ) ) uut ( .* );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic end_in_failure(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit != 0 && cycles > limit)
            end_in_failure($sformatf("timeout, test still running after %0d cycles", cycles));
    end

    task automatic check_data(string name, data_t got, data_t exp);
        if (got !== exp)
            end_in_failure($sformatf("FAIL %0t %s got %h expected %h",
                                     $time, name, got, exp));
    endtask

    task automatic check_gpio(string name, pins_t got, pins_t exp);
        if (got !== exp)
            end_in_failure($sformatf("FAIL %0t %s got %h expected %h",
                                     $time, name, got, exp));
    endtask

    task automatic check_no_ack(string when);
        if (if_req_ack_o !== 1'b0 || dm_req_ack_o !== 1'b0)
            end_in_failure({"acknowledge pulsed or unknown ", when});
    endtask

    task automatic add_op(logic port, logic we, addr_t addr, data_t wd, pins_t gpi,
                          data_t exp_rd, pins_t exp_gpo, pins_t exp_gpd);
        op_t op;
        op = '{port, we, addr, wd, gpi, exp_rd, exp_gpo, exp_gpd};
        ops.push_back(op);
    endtask

    // one request held until the ack and dropped on the next falling edge
    task automatic do_access(logic port, logic we, addr_t addr, data_t wd, output data_t rd);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        rd     = '0;
        @(negedge clk);
        if (port == port_if) begin
            if_addr_i = addr;
            if_req_i  = 1'b1;
        end else begin
            dm_addr_i = addr;
            dm_wd_i   = wd;
            dm_we_i   = we;
            dm_req_i  = 1'b1;
        end
        while (!seen) begin
            @(negedge clk);
            waited++;
            if (port == port_if ? if_req_ack_o : dm_req_ack_o) begin
                seen = 1'b1;
                rd   = (port == port_if) ? if_rd_o : dm_rd_o;
            end else if (waited >= 8)
                end_in_failure($sformatf("no acknowledge for address %h", addr));
        end
        if (waited != 2)
            end_in_failure($sformatf("acknowledge after %0d cycles, not 2", waited));
        @(negedge clk);
        if_req_i = 1'b0;
        dm_req_i = 1'b0;
        dm_we_i  = 1'b0;
    endtask

    initial begin
        data_t  rd;
        data_t  wd;
        data_t  dm_got;
        data_t  if_got;
        int     n;
        int     dm_at;
        int     if_at;
        void'($urandom(32'h7d48));
        rst_n_i   = 1'b0;
        if_addr_i = '0;
        if_req_i  = 1'b0;
        dm_addr_i = '0;
        dm_wd_i   = '0;
        dm_we_i   = 1'b0;
        dm_req_i  = 1'b0;
        gpi_i     = '0;
        dm_got    = '0;
        if_got    = '0;

        //     port     we    addr          wdata         gpi    read          gpo    gpd
        add_op(port_dm, 1'b1, 32'h0000_0000, 32'hdead_beef, 8'h00, 32'h0,         8'h00, 8'h00);
        add_op(port_dm, 1'b1, 32'h0000_0004, 32'h1234_5678, 8'h00, 32'h0,         8'h00, 8'h00);
        add_op(port_dm, 1'b1, 32'h0000_0ffc, 32'ha5a5_0f0f, 8'h00, 32'h0,         8'h00, 8'h00);
        add_op(port_dm, 1'b0, 32'h0000_0000, 32'h0,         8'h00, 32'hdead_beef, 8'h00, 8'h00);
        add_op(port_if, 1'b0, 32'h0000_0004, 32'h0,         8'h00, 32'h1234_5678, 8'h00, 8'h00);
        add_op(port_if, 1'b0, 32'h0000_0ffc, 32'h0,         8'h00, 32'ha5a5_0f0f, 8'h00, 8'h00);
        add_op(port_dm, 1'b1, 32'h0001_0000, 32'h0000_01a5, 8'h00, 32'h0,         8'ha5, 8'h00);
        add_op(port_dm, 1'b1, 32'h0001_0004, 32'h0000_00f0, 8'h00, 32'h0,         8'ha5, 8'hf0);
        add_op(port_dm, 1'b0, 32'h0001_0000, 32'h0,         8'h00, 32'h0000_00a5, 8'ha5, 8'hf0);
        add_op(port_dm, 1'b0, 32'h0001_0004, 32'h0,         8'h00, 32'h0000_00f0, 8'ha5, 8'hf0);
        add_op(port_dm, 1'b0, 32'h0001_0008, 32'h0,         8'h3c, 32'h0000_003c, 8'ha5, 8'hf0);
        add_op(port_dm, 1'b1, 32'h0001_0008, 32'h0000_00ff, 8'h81, 32'h0,         8'ha5, 8'hf0);
        add_op(port_dm, 1'b0, 32'h0001_0008, 32'h0,         8'h81, 32'h0000_0081, 8'ha5, 8'hf0);
        add_op(port_dm, 1'b1, 32'h0000_1000, 32'h7777_7777, 8'h81, 32'h0,         8'ha5, 8'hf0);
        add_op(port_dm, 1'b0, 32'h0000_1000, 32'h0,         8'h81, 32'h0,         8'ha5, 8'hf0);
        add_op(port_if, 1'b0, 32'h0001_000c, 32'h0,         8'h81, 32'h0,         8'ha5, 8'hf0);
        add_op(port_dm, 1'b0, 32'h0000_0000, 32'h0,         8'h81, 32'hdead_beef, 8'ha5, 8'hf0);
        limit = ops.size() * 8 + 2 * n_rand * 8 + 4 + 64;  // table, random phase, reset, margin

        repeat (4) begin
            @(negedge clk);
            check_no_ack("during reset");
        end
        rst_n_i = 1'b1;
        check_gpio("gpo_o", gpo_o, '0);
        check_gpio("gpd_o", gpd_o, '0);
        repeat (2) begin
            @(negedge clk);
            check_no_ack("with no request after reset");
        end

        foreach (ops[i]) begin
            gpi_i = ops[i].gpi;
            do_access(ops[i].port, ops[i].we, ops[i].addr, ops[i].wd, rd);
            if (ops[i].we && ops[i].addr < addr_t'(depth * 4))
                ref_mem[int'(ops[i].addr >> 2)] = ops[i].wd;
            else if (!ops[i].we)
                check_data(ops[i].port == port_if ? "if_rd_o" : "dm_rd_o", rd, ops[i].exp_rd);
            check_gpio("gpo_o", gpo_o, ops[i].exp_gpo);
            check_gpio("gpd_o", gpd_o, ops[i].exp_gpd);
        end

        // random words written first so repeated addresses keep the last value
        for (n = 0; n < n_rand; n++) begin
            raddr[n] = addr_t'(($urandom % depth) * 4);
            wd       = $urandom;
            do_access(port_dm, 1'b1, raddr[n], wd, rd);
            ref_mem[int'(raddr[n] >> 2)] = wd;
        end
        for (n = 0; n < n_rand; n++) begin
            do_access(n % 2 ? port_if : port_dm, 1'b0, raddr[n], '0, rd);
            check_data(n % 2 ? "if_rd_o" : "dm_rd_o", rd, ref_mem[int'(raddr[n] >> 2)]);
        end

        // both ports on one falling edge and the data port goes first
        @(negedge clk);
        dm_addr_i = 32'h0000_0000;
        dm_we_i   = 1'b0;
        dm_req_i  = 1'b1;
        if_addr_i = 32'h0000_0004;
        if_req_i  = 1'b1;
        n     = 0;
        dm_at = 0;
        if_at = 0;
        while (if_at == 0 && n < 12) begin
            @(negedge clk);
            n++;
            if (dm_at != 0)
                dm_req_i = 1'b0;    // falling edge after its ack
            if (dm_req_ack_o) begin
                dm_at  = n;
                dm_got = dm_rd_o;
            end
            if (if_req_ack_o) begin
                if_at  = n;
                if_got = if_rd_o;
            end
        end
        @(negedge clk);
        if_req_i = 1'b0;
        if (dm_at != 2 || if_at != 5)
            end_in_failure($sformatf("contention order wrong, data ack at %0d, fetch ack at %0d",
                                     dm_at, if_at));
        check_data("dm_rd_o", dm_got, ref_mem[0]);
        check_data("if_rd_o", if_got, ref_mem[1]);

        @(negedge clk);
        if (uut.nf_top_chk_0.fails == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else
            end_in_failure("handshake assertion failed in nf_top_chk");
    end

endmodule : nf_top_tb

// File: nf_soc_mem.f
nf_pkg.sv
nf_cpu_cc.sv
nf_bus_dec.sv
nf_ram.sv
nf_gpio.sv
nf_top.sv
nf_top_chk.sv
nf_top_tb.sv

// File: Makefile
# Verilator flow for nf_soc_mem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module nf_top_tb -f nf_soc_mem.f

sim:
	verilator --binary --timing --assert --top-module nf_top_tb -Mdir obj_dir -f nf_soc_mem.f
	@out="$$(./obj_dir/Vnf_top_tb)"; echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf obj_dir
